// ==== src/bp_pkg.sv ====
package bp_pkg;

    typedef logic [31:0] word_t; // program counter

    // history register width, also the width of every pattern table index
    localparam int history_depth = 8;
    localparam int pht_entries = 2 ** history_depth;

    typedef logic [history_depth-1:0] hist_t;

    // local history table is indexed by pc[7:2]
    localparam int bht_index_bits = 6;
    localparam int bht_entries = 2 ** bht_index_bits;

    typedef logic [bht_index_bits-1:0] bht_index_t;

    // msb set means taken, or prefer global for the chooser
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_reset = 2'b01; // weakly not taken / weakly local
    localparam ctr_t ctr_max = 2'b11;
    localparam ctr_t ctr_min = 2'b00;

    localparam int table_count = 3;

    typedef enum logic [1:0] {
        tbl_local,
        tbl_global,
        tbl_chooser
    } table_sel_e;

    localparam int perf_count_width = 8;

    typedef logic [perf_count_width-1:0] count_t;

endpackage : bp_pkg

// ==== src/pht_if.sv ====
interface pht_if import bp_pkg::*; ();

    hist_t rindex; // lookup side index
    hist_t windex; // resolve side index
    logic increment;
    logic decrement;
    ctr_t rctr; // counter at rindex
    ctr_t wctr; // counter at windex

    modport indexer (output rindex, output windex);

    modport tbl (
        input rindex,
        input windex,
        input increment,
        input decrement,
        output rctr,
        output wctr
    );

    modport chooser (input rctr, input wctr, output increment, output decrement);

endinterface : pht_if

// ==== src/history_indexer.sv ====
module history_indexer
import bp_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input word_t lookup_pc,
    input logic resolve_valid,
    input word_t resolve_pc,
    input logic resolve_taken,
    pht_if.indexer pht [0:table_count-1]
);

    hist_t ghr;
    hist_t bht [bht_entries];

    bht_index_t lookup_bht_idx;
    bht_index_t resolve_bht_idx;
    hist_t lookup_local_hist;
    hist_t resolve_local_hist;

    assign lookup_bht_idx = lookup_pc[bht_index_bits+1:2];
    assign resolve_bht_idx = resolve_pc[bht_index_bits+1:2];

    assign lookup_local_hist = bht[lookup_bht_idx];
    assign resolve_local_hist = bht[resolve_bht_idx];

    // both sides see the history as it is now, before this cycle's resolve
    assign pht[tbl_global].rindex = ghr;
    assign pht[tbl_global].windex = ghr;

    assign pht[tbl_local].rindex = lookup_local_hist;
    assign pht[tbl_local].windex = resolve_local_hist;

    assign pht[tbl_chooser].rindex = lookup_pc[history_depth+1:2]; // pc hashed chooser
    assign pht[tbl_chooser].windex = resolve_pc[history_depth+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ghr <= '0;
        end else if (resolve_valid) begin
            ghr <= {ghr[history_depth-2:0], resolve_taken}; // newest outcome in bit 0
        end
    end

    // per-pc history, one shift register per entry
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < bht_entries; i++) begin
                bht[i] <= '0;
            end
        end else if (resolve_valid) begin
            bht[resolve_bht_idx] <= {resolve_local_hist[history_depth-2:0], resolve_taken};
        end
    end

endmodule : history_indexer

// ==== src/pattern_table.sv ====
module pattern_table
import bp_pkg::*;
(
    input logic clk,
    input logic arst_n,
    pht_if.tbl pht
);

    ctr_t counters [pht_entries];

    logic at_max;
    logic at_min;

    // async reads on both ports
    assign pht.rctr = counters[pht.rindex];
    assign pht.wctr = counters[pht.windex];

    assign at_max = (pht.wctr == ctr_max);
    assign at_min = (pht.wctr == ctr_min);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < pht_entries; i++) begin
                counters[i] <= ctr_reset; // all start weakly not taken
            end
        end else begin
            if (pht.increment && !at_max) begin
                counters[pht.windex] <= pht.wctr + ctr_t'(1);
            end else if (pht.decrement && !at_min) begin
                counters[pht.windex] <= pht.wctr - ctr_t'(1);
            end
        end
    end

endmodule : pattern_table

// ==== src/tournament_chooser.sv ====
module tournament_chooser
import bp_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic lookup_valid,
    input logic resolve_valid,
    input logic resolve_taken,
    pht_if.chooser pht [0:table_count-1],
    output logic predict_valid,
    output logic predict_taken,
    output logic resolve_correct
);

    logic lookup_pred;
    logic resolve_pred;
    logic local_right;
    logic global_right;

    // chooser msb picks global, else local
    function automatic logic pick(ctr_t sel_ctr, ctr_t glob_ctr, ctr_t loc_ctr);
        return sel_ctr[1] ? glob_ctr[1] : loc_ctr[1];
    endfunction

    assign lookup_pred = pick(pht[tbl_chooser].rctr, pht[tbl_global].rctr,
                              pht[tbl_local].rctr);

    // prediction the resolved branch got from the pre-update counters
    assign resolve_pred = pick(pht[tbl_chooser].wctr, pht[tbl_global].wctr,
                               pht[tbl_local].wctr);

    assign local_right = (pht[tbl_local].wctr[1] == resolve_taken);
    assign global_right = (pht[tbl_global].wctr[1] == resolve_taken);

    // direction tables train toward the outcome
    assign pht[tbl_local].increment = resolve_valid && resolve_taken;
    assign pht[tbl_local].decrement = resolve_valid && !resolve_taken;
    assign pht[tbl_global].increment = resolve_valid && resolve_taken;
    assign pht[tbl_global].decrement = resolve_valid && !resolve_taken;

    // chooser only moves when the two disagree in correctness
    assign pht[tbl_chooser].increment = resolve_valid && global_right && !local_right;
    assign pht[tbl_chooser].decrement = resolve_valid && local_right && !global_right;

    assign resolve_correct = resolve_valid && (resolve_pred == resolve_taken);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            predict_valid <= 1'b0;
            predict_taken <= 1'b0;
        end else begin
            predict_valid <= lookup_valid;
            if (lookup_valid) begin
                predict_taken <= lookup_pred; // held between lookups
            end
        end
    end

endmodule : tournament_chooser

// ==== src/perf_counter.sv ====
module perf_counter
import bp_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic count,
    output count_t value,
    output logic overflow
);

    logic wrap;

    assign wrap = count && (value == '1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            value <= '0;
            overflow <= 1'b0;
        end else begin
            if (count) begin
                value <= value + count_t'(1); // wraps to zero
            end
            if (wrap) begin
                overflow <= 1'b1; // sticky until reset
            end
        end
    end

endmodule : perf_counter

// ==== src/branch_predictor.sv ====
module branch_predictor
import bp_pkg::*;
(
    input logic clk,
    input logic arst_n,

    // lookup side
    input logic lookup_valid,
    input word_t lookup_pc,

    // resolve side
    input logic resolve_valid,
    input word_t resolve_pc,
    input logic resolve_taken,

    output logic predict_valid,
    output logic predict_taken,

    // statistics
    output count_t resolve_count,
    output count_t correct_count,
    output logic resolve_overflow,
    output logic correct_overflow
);

    logic resolve_correct;

    pht_if pht [0:table_count-1] (); // one per table_sel_e entry

    history_indexer history_indexer_i (
        .clk(clk),
        .arst_n(arst_n),
        .lookup_pc(lookup_pc),
        .resolve_valid(resolve_valid),
        .resolve_pc(resolve_pc),
        .resolve_taken(resolve_taken),
        .pht(pht)
    );

    // local, global and chooser tables
    for (genvar i = 0; i < table_count; i++) begin : g_table
        localparam table_sel_e sel = table_sel_e'(i);

        pattern_table pattern_table_i (
            .clk(clk),
            .arst_n(arst_n),
            .pht(pht[sel])
        );
    end

    tournament_chooser tournament_chooser_i (
        .clk(clk),
        .arst_n(arst_n),
        .lookup_valid(lookup_valid),
        .resolve_valid(resolve_valid),
        .resolve_taken(resolve_taken),
        .pht(pht),
        .predict_valid(predict_valid),
        .predict_taken(predict_taken),
        .resolve_correct(resolve_correct)
    );

    // every resolved branch
    perf_counter resolve_counter_i (
        .clk(clk),
        .arst_n(arst_n),
        .count(resolve_valid),
        .value(resolve_count),
        .overflow(resolve_overflow)
    );

    // resolved branches the predictor got right
    perf_counter correct_counter_i (
        .clk(clk),
        .arst_n(arst_n),
        .count(resolve_correct),
        .value(correct_count),
        .overflow(correct_overflow)
    );

endmodule : branch_predictor

// ==== tests/bp_assert.sv ====
module bp_assert
import bp_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic lookup_valid,
    input logic predict_valid,
    input logic resolve_valid,
    input count_t resolve_count,
    input logic resolve_overflow,
    input logic correct_overflow
);

    timeunit 1ns;
    timeprecision 1ps;

    // prediction registered one cycle behind the lookup
    a_predict_follows_lookup: assert property (
        @(posedge clk) disable iff (!arst_n)
        predict_valid == $past(lookup_valid)
    ) else $error("predict_valid does not follow lookup_valid");

    a_resolve_count_step: assert property (
        @(posedge clk) disable iff (!arst_n)
        resolve_valid |=> resolve_count == $past(resolve_count) + count_t'(1)
    ) else $error("resolve_count did not step after a resolve");

    a_resolve_count_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        !resolve_valid |=> $stable(resolve_count)
    ) else $error("resolve_count moved without a resolve");

    // sticky flags
    a_resolve_overflow_sticky: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$fell(resolve_overflow)
    ) else $error("resolve_overflow fell outside reset");

    a_correct_overflow_sticky: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$fell(correct_overflow)
    ) else $error("correct_overflow fell outside reset");

endmodule : bp_assert

bind branch_predictor bp_assert bp_assert_i (
    .clk(clk),
    .arst_n(arst_n),
    .lookup_valid(lookup_valid),
    .predict_valid(predict_valid),
    .resolve_valid(resolve_valid),
    .resolve_count(resolve_count),
    .resolve_overflow(resolve_overflow),
    .correct_overflow(correct_overflow)
);

// ==== tests/tb_branch_predictor.sv ====
module tb_branch_predictor
import bp_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles = 16;
    localparam int random_steps = 300;
    localparam int cycle_limit = 5000; // directed plus random tests stay far below this

    logic clk;
    logic arst_n;
    logic lookup_valid;
    word_t lookup_pc;
    logic resolve_valid;
    word_t resolve_pc;
    logic resolve_taken;
    logic predict_valid;
    logic predict_taken;
    count_t resolve_count;
    count_t correct_count;
    logic resolve_overflow;
    logic correct_overflow;

    hist_t m_ghr; // reference global history
    hist_t m_bht [bht_entries];
    ctr_t m_pht [table_count][pht_entries];
    int m_resolves;
    int m_correct;

    logic exp_q [$]; // predictions still in flight
    integer seed;
    int cycle_count;
    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int errors_before;

    branch_predictor dut_i (
        .clk(clk),
        .arst_n(arst_n),
        .lookup_valid(lookup_valid),
        .lookup_pc(lookup_pc),
        .resolve_valid(resolve_valid),
        .resolve_pc(resolve_pc),
        .resolve_taken(resolve_taken),
        .predict_valid(predict_valid),
        .predict_taken(predict_taken),
        .resolve_count(resolve_count),
        .correct_count(correct_count),
        .resolve_overflow(resolve_overflow),
        .correct_overflow(correct_overflow)
    );

    always #5 clk = ~clk;

    function automatic hist_t table_index(table_sel_e sel, word_t pc);
        case (sel)
            tbl_global: return m_ghr;
            tbl_local: return m_bht[pc[7:2]];
            default: return pc[9:2]; // chooser
        endcase
    endfunction

    // reference prediction from the current model state
    function automatic logic expected_prediction(word_t pc);
        ctr_t sel_ctr;
        sel_ctr = m_pht[tbl_chooser][table_index(tbl_chooser, pc)];
        if (sel_ctr[1]) begin
            return m_pht[tbl_global][table_index(tbl_global, pc)][1];
        end
        return m_pht[tbl_local][table_index(tbl_local, pc)][1];
    endfunction

    function automatic ctr_t step_ctr(ctr_t c, logic up);
        if (up) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    task automatic model_reset();
        m_ghr = '0;
        m_resolves = 0;
        m_correct = 0;
        exp_q.delete();
        for (int i = 0; i < bht_entries; i++) begin
            m_bht[i] = '0;
        end
        for (int t = 0; t < table_count; t++) begin
            for (int i = 0; i < pht_entries; i++) begin
                m_pht[t][i] = 2'b01; // weakly not taken, weakly local
            end
        end
    endtask

    task automatic model_resolve(word_t pc, logic taken);
        hist_t li;
        hist_t gi;
        hist_t ci;
        logic l_right;
        logic g_right;
        li = table_index(tbl_local, pc);
        gi = table_index(tbl_global, pc);
        ci = table_index(tbl_chooser, pc);
        l_right = (m_pht[tbl_local][li][1] == taken);
        g_right = (m_pht[tbl_global][gi][1] == taken);
        if (expected_prediction(pc) == taken) begin
            m_correct++;
        end
        m_resolves++;
        m_pht[tbl_local][li] = step_ctr(m_pht[tbl_local][li], taken);
        m_pht[tbl_global][gi] = step_ctr(m_pht[tbl_global][gi], taken);
        if (g_right && !l_right) begin
            m_pht[tbl_chooser][ci] = step_ctr(m_pht[tbl_chooser][ci], 1'b1);
        end else if (l_right && !g_right) begin
            m_pht[tbl_chooser][ci] = step_ctr(m_pht[tbl_chooser][ci], 1'b0);
        end
        m_bht[pc[7:2]] = {m_bht[pc[7:2]][history_depth-2:0], taken};
        m_ghr = {m_ghr[history_depth-2:0], taken};
    endtask

    task automatic check_pred(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s predicted %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(count_t got, count_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_counters();
        check_count(resolve_count, count_t'(m_resolves), "resolve_count");
        check_count(correct_count, count_t'(m_correct), "correct_count");
        check_flag(resolve_overflow, m_resolves >= (1 << perf_count_width), "resolve_overflow");
        check_flag(correct_overflow, m_correct >= (1 << perf_count_width), "correct_overflow");
    endtask

    task automatic drive_cycle(logic lv, word_t lpc, logic rv, word_t rpc, logic rt);
        @(posedge clk);
        lookup_valid <= lv;
        lookup_pc <= lpc;
        resolve_valid <= rv;
        resolve_pc <= rpc;
        resolve_taken <= rt;
        if (lv) begin
            exp_q.push_back(expected_prediction(lpc)); // state before this cycle's resolve
        end
        if (rv) begin
            model_resolve(rpc, rt);
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0);
    endtask

    task automatic drain_predictions();
        idle_cycle();
        while (exp_q.size() != 0) begin
            idle_cycle();
        end
        @(negedge clk); // outputs settled
    endtask

    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        lookup_valid <= 1'b0;
        resolve_valid <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;
        model_reset();
    endtask

    task automatic report_test(string name);
        check_counters();
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("test %-14s %s (%0d errors)", name,
                 (errors == errors_before) ? "ok" : "FAILED", errors - errors_before);
        errors_before = errors;
    endtask

    // checks every registered prediction against the model
    always @(negedge clk) begin
        if (predict_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("prediction at %0t with no lookup outstanding", $time);
            end else begin
                check_pred(predict_taken, exp_q.pop_front(), "lookup");
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        word_t pc_a;
        word_t pc_b;
        logic outcome;
        logic [31:0] r;
        clk = 1'b0;
        arst_n = 1'b0;
        lookup_valid = 1'b0;
        lookup_pc = '0;
        resolve_valid = 1'b0;
        resolve_pc = '0;
        resolve_taken = 1'b0;
        seed = 32'hc9d;
        cycle_count = 0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        errors_before = 0;
        apply_reset();

        @(negedge clk);
        check_flag(predict_valid, 1'b0, "predict_valid after reset");
        check_flag(predict_taken, 1'b0, "predict_taken after reset");
        check_counters();
        r = $random(seed);
        drive_cycle(1'b1, {r[31:2], 2'b00}, 1'b0, '0, 1'b0);
        drain_predictions();
        check_flag(predict_taken, 1'b0, "first lookup");
        report_test("reset");

        pc_a = 32'h0000_0100;
        for (int i = 0; i < 20; i++) begin // training, then further taken resolves
            drive_cycle(1'b1, pc_a, 1'b0, '0, 1'b0);
            drive_cycle(1'b0, '0, 1'b1, pc_a, 1'b1);
        end
        drive_cycle(1'b1, pc_a, 1'b0, '0, 1'b0);
        drain_predictions();
        check_flag(predict_taken, 1'b1, "always taken branch");
        report_test("always_taken");

        pc_a = 32'h0000_0204;
        outcome = 1'b1;
        for (int i = 0; i < 48; i++) begin
            drive_cycle(1'b1, pc_a, 1'b0, '0, 1'b0);
            drive_cycle(1'b0, '0, 1'b1, pc_a, outcome);
            outcome = !outcome;
        end
        drive_cycle(1'b1, pc_a, 1'b0, '0, 1'b0);
        drain_predictions();
        check_flag(predict_taken, outcome, "alternating branch");
        report_test("alternating");

        pc_a = 32'h0000_0300;
        pc_b = 32'h0000_0340; // follows pc_a
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            drive_cycle(1'b1, pc_a, 1'b0, '0, 1'b0);
            drive_cycle(1'b0, '0, 1'b1, pc_a, r[0]);
            drive_cycle(1'b1, pc_b, 1'b0, '0, 1'b0);
            drive_cycle(1'b0, '0, 1'b1, pc_b, r[0]);
        end
        drain_predictions();
        report_test("correlated");

        pc_a = 32'h0000_03a8;
        for (int i = 0; i < 12; i++) begin
            r = $random(seed);
            drive_cycle(1'b1, pc_a, 1'b1, pc_a, r[0]);
        end
        drain_predictions();
        report_test("same_cycle");

        apply_reset();
        for (int i = 0; i < random_steps; i++) begin
            r = $random(seed);
            drive_cycle(r[0], {22'd0, r[11:4], 2'b00}, 1'b1, {22'd0, r[19:12], 2'b00}, r[1]);
            if (i == 255 || i == 256) begin
                @(negedge clk); // i resolves applied so far
                check_count(resolve_count, count_t'(i), "resolve_count around wrap");
                check_flag(resolve_overflow, i >= 256, "resolve_overflow around wrap");
            end
        end
        drain_predictions();
        check_flag(resolve_overflow, 1'b1, "resolve_overflow after wrap");
        report_test("random");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_branch_predictor

// ==== build.f ====
src/bp_pkg.sv
src/pht_if.sv
src/history_indexer.sv
src/pattern_table.sv
src/tournament_chooser.sv
src/perf_counter.sv
src/branch_predictor.sv
tests/bp_assert.sv
tests/tb_branch_predictor.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_branch_predictor
FILELIST := build.f

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := obj_dir/V$(TOP)
LOG      := sim.log

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
